//--- design/vlane_pkg.sv
////////////////////
// Shared sizes for the sub-lane driver
// Instruction kind, FSM state and element width enums
// Byte-enable type
////////////////////

package vlane_pkg;

    ////////////////////
    // Sizes
    localparam int VLANE_NUM       = 8;
    localparam int MEM_DEPTH       = 512;                       // Words per lane
    localparam int ADDR_W          = $clog2(MEM_DEPTH);
    localparam int MAX_VL_PER_LANE = 256;
    localparam int VL_W            = $clog2(VLANE_NUM * MAX_VL_PER_LANE);
    localparam int CNT_W           = $clog2(MAX_VL_PER_LANE) + 1;
    localparam int RD_PORTS        = 3;                          // vs1, vs2, vs3
    localparam int LANE_SH         = $clog2(VLANE_NUM);         // vl to per-lane shift

    ////////////////////
    // Encodings
    typedef enum logic [1:0] {
        KIND_NORMAL,
        KIND_STORE,
        KIND_LOAD
    } inst_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_NORMAL,
        ST_READ,
        ST_LOAD
    } drv_state_e;

    // Elements per 32-bit word are 4, 2 and 1
    typedef enum logic [1:0] {
        EW_BYTE = 2'd1,
        EW_HALF = 2'd2,
        EW_WORD = 2'd3
    } elem_width_e;

    typedef logic [3:0] bwen_t;

endpackage

//--- design/inst_cfg_if.sv
////////////////////
// Latched instruction fields from the config block
// to the sequencer and the write port
////////////////////

`timescale 1ns/1ps

interface inst_cfg_if import vlane_pkg::*; ();

    logic                           go;             // One cycle after an accepted start
    inst_kind_e                     kind;
    logic [CNT_W-1:0]               inst_delay;
    logic [CNT_W-1:0]               read_limit;     // Elements per lane
    elem_width_e                    wr_width;
    elem_width_e                    rd_width;
    logic [ADDR_W-1:0]              waddr_start;
    logic [RD_PORTS-1:0][ADDR_W-1:0] raddr_start;
    logic                           ready;

    modport cfg (output go, kind, inst_delay, read_limit, wr_width, rd_width,
                 output waddr_start, raddr_start, input ready);

    modport seq (input go, kind, inst_delay, read_limit, wr_width, rd_width,
                 input waddr_start, raddr_start, output ready);

endinterface

//--- design/inst_config_regs.sv
////////////////////
// Instruction configuration registers
// Captures the fields on an accepted start and
// computes the per-lane element count
////////////////////

`timescale 1ns/1ps

module inst_config_regs import vlane_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  inst_kind_e                      kind_i,
    input  logic [VL_W-1:0]                 vl_i,
    input  logic [CNT_W-1:0]                inst_delay_i,
    input  elem_width_e                     wr_width_i,
    input  elem_width_e                     rd_width_i,
    input  logic [ADDR_W-1:0]               waddr_i,
    input  logic [RD_PORTS-1:0][ADDR_W-1:0] raddr_i,
    inst_cfg_if.cfg                         cfg
);

    logic             accept;
    logic [CNT_W-1:0] lane_elems;

    assign accept = start_i && cfg.ready;

    // ceil(vl / VLANE_NUM)
    assign lane_elems = CNT_W'(vl_i[VL_W-1:LANE_SH]) + CNT_W'(|vl_i[LANE_SH-1:0]);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cfg.go <= 1'b0;
        end else begin
            cfg.go <= accept;
        end
    end

    ////////////////////
    // Field capture
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cfg.kind        <= kind_i;
            cfg.inst_delay  <= inst_delay_i;
            cfg.read_limit  <= lane_elems;
            cfg.wr_width    <= wr_width_i;
            cfg.rd_width    <= rd_width_i;
            cfg.waddr_start <= waddr_i;
            cfg.raddr_start <= raddr_i;
        end
    end

    // Sequencer only handles the three kinds it knows
    a_kind_defined: assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> kind_i inside {KIND_NORMAL, KIND_STORE, KIND_LOAD})
        else $error("undefined instruction kind accepted");

endmodule

//--- design/lane_sequencer.sv
////////////////////
// Driver FSM with the main counter
// Ready, store valid, load ready and the
// read/write enables for the address counters
////////////////////

`timescale 1ns/1ps

module lane_sequencer import vlane_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    inst_cfg_if.seq cfg,
    input  logic    load_last_i,
    output logic    ready_o,
    output logic    ready_for_load_o,
    output logic    store_data_valid_o,
    output logic    cnt_load_o,
    output logic    rd_en_o,
    output logic    wr_en_o,
    output logic    load_mode_o
);

    drv_state_e     state, next_state;
    logic [CNT_W:0] main_cnt;       // Spans inst_delay plus read_limit
    logic [CNT_W:0] normal_end;
    logic [CNT_W:0] cnt_plus;

    assign normal_end = {1'b0, cfg.inst_delay} + {1'b0, cfg.read_limit};
    assign cnt_plus   = main_cnt + 1'b1;

    ////////////////////
    // State and main counter
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state    <= ST_IDLE;
            main_cnt <= '0;
        end else begin
            state <= next_state;
            if (next_state != state) begin
                main_cnt <= '0;             // Every mode starts from 0
            end else if (state == ST_NORMAL || state == ST_READ) begin
                main_cnt <= cnt_plus;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (cfg.go) begin
                    case (cfg.kind)
                        KIND_NORMAL: next_state = ST_NORMAL;
                        KIND_STORE:  next_state = ST_READ;
                        KIND_LOAD:   next_state = ST_LOAD;
                        default:     next_state = ST_IDLE;
                    endcase
                end
            end
            ST_NORMAL: begin
                // Last write cycle closes the instruction
                if (cnt_plus >= normal_end) begin
                    next_state = ST_IDLE;
                end
            end
            ST_READ: begin
                if (cnt_plus >= {1'b0, cfg.read_limit}) begin
                    next_state = ST_IDLE;
                end
            end
            ST_LOAD: begin
                if (load_last_i) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    ////////////////////
    // Outputs
    // Low from the cycle after an accepted start
    assign ready_o   = (state == ST_IDLE) && !cfg.go;
    assign cfg.ready = ready_o;

    assign cnt_load_o         = (state == ST_IDLE) && cfg.go;
    assign rd_en_o            = (state == ST_NORMAL) || (state == ST_READ);
    assign store_data_valid_o = (state == ST_READ);
    assign ready_for_load_o   = (state == ST_LOAD);
    assign load_mode_o        = (state == ST_LOAD);

    // Write window after the pipeline delay
    assign wr_en_o = (state == ST_NORMAL) && (main_cnt >= {1'b0, cfg.inst_delay}) &&
                     (main_cnt < normal_end);

    a_wr_store_excl: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(wr_en_o && store_data_valid_o))
        else $error("write enable and store valid overlap");

    // A go pulse in IDLE starts a mode and keeps ready low
    a_busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state == ST_IDLE && cfg.go) |=> (state != ST_IDLE) && !ready_o)
        else $error("go did not start an instruction with ready low");

endmodule

//--- design/vrf_addr_counter.sv
////////////////////
// VRF word address counter
// Advances once per word of elements
////////////////////

`timescale 1ns/1ps

module vrf_addr_counter import vlane_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              load_i,
    input  logic [ADDR_W-1:0] start_addr_i,
    input  elem_width_e       width_i,
    input  logic              en_i,
    output logic [ADDR_W-1:0] addr_o,
    output logic [1:0]        sub_idx_o
);

    logic word_full;

    // Last element slot of the current word
    always_comb begin
        case (width_i)
            EW_BYTE: word_full = (sub_idx_o == 2'd3);
            EW_HALF: word_full = (sub_idx_o == 2'd1);
            default: word_full = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_o    <= '0;
            sub_idx_o <= '0;
        end else if (load_i) begin
            addr_o    <= start_addr_i;
            sub_idx_o <= '0;
        end else if (en_i) begin
            if (word_full) begin
                addr_o    <= addr_o + 1'b1;
                sub_idx_o <= '0;
            end else begin
                sub_idx_o <= sub_idx_o + 1'b1;
            end
        end
    end

endmodule

//--- design/vrf_write_port.sv
////////////////////
// VRF write address and byte enables
// Normal writes by element width, loads by beat
////////////////////

`timescale 1ns/1ps

module vrf_write_port import vlane_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    inst_cfg_if.seq           cfg,
    input  logic              cnt_load_i,
    input  logic              wr_en_i,
    input  logic              load_mode_i,
    input  logic              load_valid_i,
    input  bwen_t             load_bwen_i,
    output logic [ADDR_W-1:0] vrf_waddr_o,
    output bwen_t             vrf_bwen_o
);

    elem_width_e cnt_width;
    logic        cnt_en;
    logic [1:0]  sub_idx;
    bwen_t       elem_bwen;

    // Load data always arrives as full words
    always_comb begin
        if (load_mode_i) begin
            cnt_width = EW_WORD;
            cnt_en    = load_valid_i;
        end else begin
            cnt_width = cfg.wr_width;
            cnt_en    = wr_en_i;
        end
    end

    vrf_addr_counter u_waddr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (cnt_load_i),
        .start_addr_i (cfg.waddr_start),
        .width_i      (cnt_width),
        .en_i         (cnt_en),
        .addr_o       (vrf_waddr_o),
        .sub_idx_o    (sub_idx)
    );

    always_comb begin
        case (cfg.wr_width)
            EW_BYTE: elem_bwen = bwen_t'(4'b0001 << sub_idx);
            EW_HALF: elem_bwen = sub_idx[0] ? 4'b1100 : 4'b0011;
            EW_WORD: elem_bwen = 4'b1111;
            default: elem_bwen = 4'b0000;
        endcase
    end

    assign vrf_bwen_o = load_mode_i ? (load_valid_i ? load_bwen_i : '0) :
                        (wr_en_i ? elem_bwen : '0);

endmodule

//--- design/vlane_driver_top.sv
////////////////////
// Sub-lane driver top level
// Config block, FSM, three read counters, write port
////////////////////

`timescale 1ns/1ps

module vlane_driver_top import vlane_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  inst_kind_e                      kind_i,
    input  logic [VL_W-1:0]                 vl_i,
    input  logic [CNT_W-1:0]                inst_delay_i,
    input  elem_width_e                     wr_width_i,
    input  elem_width_e                     rd_width_i,
    input  logic [ADDR_W-1:0]               waddr_i,
    input  logic [RD_PORTS-1:0][ADDR_W-1:0] raddr_i,
    input  logic                            load_valid_i,
    input  logic                            load_last_i,
    input  bwen_t                           load_bwen_i,
    output logic                            ready_o,
    output logic                            ready_for_load_o,
    output logic                            store_data_valid_o,
    output logic [RD_PORTS-1:0][ADDR_W-1:0] vrf_raddr_o,
    output logic [ADDR_W-1:0]               vrf_waddr_o,
    output bwen_t                           vrf_bwen_o
);

    logic cnt_load;
    logic rd_en;
    logic wr_en;
    logic load_mode;

    inst_cfg_if cfg_bus ();

    inst_config_regs u_cfg (
        .clk_i, .rst_i, .start_i, .kind_i, .vl_i, .inst_delay_i,
        .wr_width_i, .rd_width_i, .waddr_i, .raddr_i,
        .cfg (cfg_bus.cfg)
    );

    lane_sequencer u_seq (
        .clk_i, .rst_i, .load_last_i, .ready_o, .ready_for_load_o, .store_data_valid_o,
        .cfg         (cfg_bus.seq),
        .cnt_load_o  (cnt_load),
        .rd_en_o     (rd_en),
        .wr_en_o     (wr_en),
        .load_mode_o (load_mode)
    );

    // One counter per read port with a shared width
    for (genvar i = 0; i < RD_PORTS; i++) begin : g_rd_cnt
        vrf_addr_counter u_raddr_cnt (
            .clk_i, .rst_i,
            .load_i       (cnt_load),
            .start_addr_i (cfg_bus.raddr_start[i]),
            .width_i      (cfg_bus.rd_width),
            .en_i         (rd_en),
            .addr_o       (vrf_raddr_o[i]),
            .sub_idx_o    ()
        );
    end

    vrf_write_port u_wr_port (
        .clk_i, .rst_i, .load_valid_i, .load_bwen_i, .vrf_waddr_o, .vrf_bwen_o,
        .cfg         (cfg_bus.seq),
        .cnt_load_i  (cnt_load),
        .wr_en_i     (wr_en),
        .load_mode_i (load_mode)
    );

endmodule

//--- dv/tb_vlane_driver.sv
////////////////////
// Testbench for the sub-lane driver
// Runs NORMAL, STORE and LOAD records from the stimulus file
////////////////////

`timescale 1ns/1ps

module tb_vlane_driver import vlane_pkg::*; ();

    localparam int NUM_REC  = 8;
    localparam int NUM_FLD  = 15;       // Fields per stimulus line
    localparam int MAX_WAIT = 1000;     // Cycles per wait loop

    logic                            clk_i = 1'b0;
    logic                            rst_i;
    logic                            start_i;
    inst_kind_e                      kind_i;
    logic [VL_W-1:0]                 vl_i;
    logic [CNT_W-1:0]                inst_delay_i;
    elem_width_e                     wr_width_i;
    elem_width_e                     rd_width_i;
    logic [ADDR_W-1:0]               waddr_i;
    logic [RD_PORTS-1:0][ADDR_W-1:0] raddr_i;
    logic                            load_valid_i;
    logic                            load_last_i;
    bwen_t                           load_bwen_i;
    logic                            ready_o;
    logic                            ready_for_load_o;
    logic                            store_data_valid_o;
    logic [RD_PORTS-1:0][ADDR_W-1:0] vrf_raddr_o;
    logic [ADDR_W-1:0]               vrf_waddr_o;
    bwen_t                           vrf_bwen_o;

    logic [15:0] stim [0:NUM_REC*NUM_FLD-1];
    integer      seed    = 81;
    int          errors  = 0;
    bit          aborted = 0;

    always #5 clk_i = ~clk_i;

    vlane_driver_top uut (.*);

    ////////////////////
    // Helpers
    task automatic report_value(input string name, input int r,
                                input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] rec %0d %s: got 0x%0h, expected 0x%0h", r, name, got, exp);
        errors++;
    endtask

    // Byte lanes of write number k within one instruction
    function automatic bwen_t width_pattern(elem_width_e w, int k);
        case (w)
            EW_BYTE: return bwen_t'(1 << (k % 4));
            EW_HALF: return (k % 2 == 1) ? 4'hC : 4'h3;
            default: return 4'hF;
        endcase
    endfunction

    task automatic run_record(input int r);
        int                base;
        int                waited;
        int                writes;
        int                stores;
        int                exp_stores;
        int                beats_left;
        bit                prev_store;
        logic [31:0]       rnd;
        bwen_t             exp_bwen;
        inst_kind_e        kind;
        elem_width_e       wr_w;
        logic [ADDR_W-1:0] last_waddr;
        logic [ADDR_W-1:0] beat_addr;
        base       = r * NUM_FLD;
        kind       = inst_kind_e'(stim[base][1:0]);
        wr_w       = elem_width_e'(stim[base+3][1:0]);
        beats_left = stim[base+9];
        beat_addr  = stim[base+5][ADDR_W-1:0];
        writes     = 0;
        stores     = 0;
        prev_store = 1'b0;
        last_waddr = '0;
        exp_stores = (kind == KIND_STORE) ? (stim[base+1] + 7) / 8 : 0;
        waited     = 0;
        while (!ready_o && waited < MAX_WAIT) begin
            @(negedge clk_i);
            #1;
            waited++;
        end
        if (!ready_o) begin
            $display("Timeout: ready_o stayed low before record %0d", r);
            errors++;
            aborted = 1;
            return;
        end
        @(negedge clk_i);
        start_i      = 1'b1;
        kind_i       = kind;
        vl_i         = stim[base+1][VL_W-1:0];
        inst_delay_i = stim[base+2][CNT_W-1:0];
        wr_width_i   = wr_w;
        rd_width_i   = elem_width_e'(stim[base+4][1:0]);
        waddr_i      = stim[base+5][ADDR_W-1:0];
        for (int p = 0; p < RD_PORTS; p++) begin
            raddr_i[p] = stim[base+6+p][ADDR_W-1:0];
        end
        // Second start while busy is dropped
        @(negedge clk_i);
        kind_i  = KIND_LOAD;
        vl_i    = ~vl_i;
        waddr_i = ~waddr_i;
        #1;
        if (ready_o !== 1'b0) report_value("ready_o", r, ready_o, 0);
        waited = 0;
        while (waited < MAX_WAIT) begin
            @(negedge clk_i);
            start_i      = 1'b0;
            load_valid_i = 1'b0;
            load_last_i  = 1'b0;
            load_bwen_i  = '0;
            if (kind == KIND_LOAD && beats_left > 0) begin
                rnd          = $random(seed);
                load_valid_i = rnd[0];
                load_bwen_i  = rnd[7:4];
                load_last_i  = rnd[0] && (beats_left == 1);
                beats_left   = beats_left - int'(rnd[0]);
            end
            #1;
            if (ready_o) break;
            waited++;
            if (kind == KIND_LOAD) begin
                if (ready_for_load_o !== 1'b1) begin
                    report_value("ready_for_load_o", r, ready_for_load_o, 1);
                end
                exp_bwen = load_valid_i ? load_bwen_i : 4'h0;
                if (vrf_bwen_o !== exp_bwen) report_value("vrf_bwen_o", r, vrf_bwen_o, exp_bwen);
                if (load_valid_i) begin
                    if (vrf_waddr_o !== beat_addr) begin
                        report_value("vrf_waddr_o", r, vrf_waddr_o, beat_addr);
                    end
                    last_waddr = vrf_waddr_o;
                    beat_addr  = beat_addr + 1'b1;
                    writes++;
                end
            end else begin
                if (ready_for_load_o !== 1'b0) begin
                    report_value("ready_for_load_o", r, ready_for_load_o, 0);
                end
                if (vrf_bwen_o != 4'h0) begin
                    exp_bwen = width_pattern(wr_w, writes);
                    if (vrf_bwen_o !== exp_bwen) begin
                        report_value("vrf_bwen_o", r, vrf_bwen_o, exp_bwen);
                    end
                    last_waddr = vrf_waddr_o;
                    writes++;
                end
                if (store_data_valid_o) begin
                    if (stores > 0 && !prev_store) begin
                        $display("[ERROR] rec %0d store_data_valid_o has a gap", r);
                        errors++;
                    end
                    stores++;
                end
                prev_store = store_data_valid_o;
            end
        end
        if (!ready_o) begin
            $display("Timeout: record %0d never returned to ready", r);
            errors++;
            aborted = 1;
            return;
        end
        if (writes != stim[base+10]) report_value("vrf_bwen_o writes", r, writes, stim[base+10]);
        if (writes > 0 && last_waddr !== stim[base+11][ADDR_W-1:0]) begin
            report_value("last vrf_waddr_o", r, last_waddr, stim[base+11]);
        end
        if (stores != exp_stores) report_value("store_data_valid_o cycles", r, stores, exp_stores);
        for (int p = 0; p < RD_PORTS; p++) begin
            if (vrf_raddr_o[p] !== stim[base+12+p][ADDR_W-1:0]) begin
                report_value($sformatf("vrf_raddr_o[%0d]", p), r, vrf_raddr_o[p],
                             stim[base+12+p]);
            end
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        rst_i        = 1'b0;
        start_i      = 1'b0;
        kind_i       = KIND_NORMAL;
        vl_i         = '0;
        inst_delay_i = '0;
        wr_width_i   = EW_WORD;
        rd_width_i   = EW_WORD;
        waddr_i      = '0;
        raddr_i      = '0;
        load_valid_i = 1'b0;
        load_last_i  = 1'b0;
        load_bwen_i  = '0;
        $readmemh("dv/driver_stimulus.txt", stim);
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;
        #1;
        if (ready_o !== 1'b1) report_value("ready_o", -1, ready_o, 1);
        if (ready_for_load_o !== 1'b0) report_value("ready_for_load_o", -1, ready_for_load_o, 0);
        if (store_data_valid_o !== 1'b0) begin
            report_value("store_data_valid_o", -1, store_data_valid_o, 0);
        end
        if (vrf_bwen_o !== 4'h0) report_value("vrf_bwen_o", -1, vrf_bwen_o, 0);
        for (int r = 0; r < NUM_REC && !aborted; r++) begin
            run_record(r);
        end
        $display("Run complete: %0d records, %0d errors", NUM_REC, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- dv/driver_stimulus.txt
// kind vl delay wr_w rd_w waddr ra0 ra1 ra2 beats | exp_writes exp_last_waddr exp_ra0 exp_ra1 exp_ra2
// kind 0 normal 1 store 2 load, width 1 byte 2 half 3 word, all values hex
0 040 3 1 2 010 020 030 040 0 8   011 025 035 045
0 015 0 2 3 1f0 100 101 102 0 3   1f1 103 104 105
1 028 0 3 1 050 060 070 080 0 0   000 061 071 081
2 008 0 3 3 0a0 0b0 0c0 0d0 6 6   0a5 0b0 0c0 0d0
0 7ff 2 3 1 000 001 002 003 0 100 0ff 041 042 043
1 001 0 1 3 033 1fe 1ff 000 0 0   000 1ff 000 001
2 010 0 1 2 1fc 010 011 012 8 8   003 010 011 012
0 00c 5 1 1 123 000 100 1ff 0 2   123 001 101 000

//--- compile.f
design/vlane_pkg.sv
design/inst_cfg_if.sv
design/inst_config_regs.sv
design/lane_sequencer.sv
design/vrf_addr_counter.sv
design/vrf_write_port.sv
design/vlane_driver_top.sv
dv/tb_vlane_driver.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_vlane_driver
FILELIST  = compile.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
